//--- common/id_pkg.sv
`default_nettype none

package id_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////

	localparam int WAYS      = 2;                    // instructions per bundle
	localparam int XLEN      = 32;
	localparam int ARF_SIZE  = 32;                   // architectural registers
	localparam int PRF_SIZE  = 64;                   // physical registers
	localparam int FREE_SIZE = PRF_SIZE - ARF_SIZE;  // free list depth
	localparam int ARN_W     = 5;
	localparam int PRN_W     = 6;
	localparam int FREE_W    = $clog2(FREE_SIZE);    // free list pointer
	localparam int CNT_W     = FREE_W + 1;           // count must reach FREE_SIZE

	localparam logic [XLEN-1:0] WFI_INST = 32'h1050_0073;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// rv32 major opcodes
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
	} alu_func_e;

	typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM
	} opb_sel_e;

	typedef enum logic {DEST_NONE, DEST_RD} dest_sel_e;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

	////////////////////////////////////////
	// packets
	////////////////////////////////////////

	typedef struct packed {
		logic [XLEN-1:0] instruction;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] npc;
		logic            valid;
	} if_id_packet_t;

	typedef struct packed {
		opa_sel_e  opa_sel;
		opb_sel_e  opb_sel;
		alu_func_e alu_func;
		dest_sel_e dest_sel;
		logic      rd_mem;
		logic      wr_mem;
		logic      cond_branch;
		logic      uncond_branch;
		logic      csr_op;
		logic      halt;
		logic      illegal;
		mem_size_e mem_size;
		logic      valid_inst;
	} decode_t;

	typedef struct packed {
		logic [XLEN-1:0]  pc;
		logic [XLEN-1:0]  npc;
		logic [XLEN-1:0]  instruction;
		opa_sel_e         opa_sel;
		opb_sel_e         opb_sel;
		alu_func_e        alu_func;
		logic             rd_mem;
		logic             wr_mem;
		logic             cond_branch;
		logic             uncond_branch;
		logic             csr_op;
		logic             halt;
		logic             illegal;
		mem_size_e        mem_size;
		logic             valid_inst;
		logic [PRN_W-1:0] dest_prn;
		logic [XLEN-1:0]  rs1_value;   // prn when not ready
		logic [XLEN-1:0]  rs2_value;
		logic             opa_ready;
		logic             opb_ready;
		logic             valid;
	} id_ex_packet_t;

	typedef struct packed {
		logic             valid;
		logic [PRN_W-1:0] prn;
		logic [XLEN-1:0]  data;
	} cdb_t;

	typedef struct packed {
		logic             valid;
		logic [ARN_W-1:0] arn;
		logic [PRN_W-1:0] prn;
	} retire_t;

endpackage

`default_nettype wire

//--- hdl/decoder.sv
`default_nettype none

module decoder import id_pkg::*; (
	input  wire if_id_packet_t packet,
	output decode_t            dec
);

	logic [XLEN-1:0] inst;
	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;

	assign inst   = packet.instruction;
	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		// defaults are a nop, add with no destination
		dec.opa_sel       = OPA_RS1;
		dec.opb_sel       = OPB_RS2;
		dec.alu_func      = ALU_ADD;
		dec.dest_sel      = DEST_NONE;
		dec.rd_mem        = 1'b0;
		dec.wr_mem        = 1'b0;
		dec.cond_branch   = 1'b0;
		dec.uncond_branch = 1'b0;
		dec.csr_op        = 1'b0;
		dec.halt          = 1'b0;
		dec.illegal       = 1'b0;
		dec.mem_size      = MEM_BYTE;
		if (packet.valid) begin
			case (opcode)
				OPC_LUI: begin
					dec.dest_sel = DEST_RD;
					dec.opa_sel  = OPA_ZERO;
					dec.opb_sel  = OPB_U_IMM;
				end
				OPC_AUIPC: begin
					dec.dest_sel = DEST_RD;
					dec.opa_sel  = OPA_PC;
					dec.opb_sel  = OPB_U_IMM;
				end
				OPC_JAL: begin
					dec.dest_sel      = DEST_RD;
					dec.opa_sel       = OPA_PC;
					dec.opb_sel       = OPB_J_IMM;
					dec.uncond_branch = 1'b1;
				end
				OPC_JALR: begin
					dec.dest_sel      = DEST_RD;
					dec.opb_sel       = OPB_I_IMM;
					dec.uncond_branch = 1'b1;
					dec.illegal       = (funct3 != 3'b000);
				end
				OPC_BRANCH: begin
					dec.opa_sel     = OPA_PC;
					dec.opb_sel     = OPB_B_IMM;
					dec.cond_branch = 1'b1;
					dec.illegal     = (funct3[2:1] == 2'b01);  // 010 and 011 unused
				end
				OPC_LOAD: begin
					dec.dest_sel = DEST_RD;
					dec.opb_sel  = OPB_I_IMM;
					dec.rd_mem   = 1'b1;
					if (funct3[1:0] == 2'b11 || funct3 == 3'b110)
						dec.illegal = 1'b1;
					else
						dec.mem_size = mem_size_e'(funct3[1:0]);
				end
				OPC_STORE: begin
					dec.opb_sel = OPB_S_IMM;
					dec.wr_mem  = 1'b1;
					if (funct3[2] || funct3[1:0] == 2'b11)
						dec.illegal = 1'b1;
					else
						dec.mem_size = mem_size_e'(funct3[1:0]);
				end
				OPC_OP_IMM: begin
					dec.dest_sel = DEST_RD;
					dec.opb_sel  = OPB_I_IMM;
					casez ({funct7, funct3})
						10'b???????_000: dec.alu_func = ALU_ADD;
						10'b???????_010: dec.alu_func = ALU_SLT;
						10'b???????_011: dec.alu_func = ALU_SLTU;
						10'b???????_100: dec.alu_func = ALU_XOR;
						10'b???????_110: dec.alu_func = ALU_OR;
						10'b???????_111: dec.alu_func = ALU_AND;
						10'b0000000_001: dec.alu_func = ALU_SLL;  // shamt in rs2 field
						10'b0000000_101: dec.alu_func = ALU_SRL;
						10'b0100000_101: dec.alu_func = ALU_SRA;
						default:         dec.illegal  = 1'b1;
					endcase
				end
				OPC_OP: begin
					dec.dest_sel = DEST_RD;
					casez ({funct7, funct3})
						10'b0000000_000: dec.alu_func = ALU_ADD;
						10'b0100000_000: dec.alu_func = ALU_SUB;
						10'b0000000_001: dec.alu_func = ALU_SLL;
						10'b0000000_010: dec.alu_func = ALU_SLT;
						10'b0000000_011: dec.alu_func = ALU_SLTU;
						10'b0000000_100: dec.alu_func = ALU_XOR;
						10'b0000000_101: dec.alu_func = ALU_SRL;
						10'b0100000_101: dec.alu_func = ALU_SRA;
						10'b0000000_110: dec.alu_func = ALU_OR;
						10'b0000000_111: dec.alu_func = ALU_AND;
						10'b0000001_000: dec.alu_func = ALU_MUL;
						10'b0000001_001: dec.alu_func = ALU_MULH;
						10'b0000001_010: dec.alu_func = ALU_MULHSU;
						10'b0000001_011: dec.alu_func = ALU_MULHU;
						default:         dec.illegal  = 1'b1;  // divides land here
					endcase
				end
				OPC_SYSTEM: begin
					if (inst == WFI_INST)
						dec.halt = 1'b1;
					else if (funct3[1:0] != 2'b00)
						dec.csr_op = 1'b1;  // csrrw/s/c and immediate forms
					else
						dec.illegal = 1'b1;
				end
				default: dec.illegal = 1'b1;
			endcase
		end
		dec.valid_inst = packet.valid & ~dec.illegal;
	end

endmodule

`default_nettype wire

//--- rename/rename_table.sv
`default_nettype none

module rename_table import id_pkg::*; (
	input  wire logic                          clock,
	input  wire logic                          rst,
	input  wire logic                          except,
	input  wire logic [WAYS-1:0][1:0][ARN_W-1:0] src_arn,
	input  wire logic [WAYS-1:0][ARN_W-1:0]    dest_arn,
	input  wire logic [WAYS-1:0]               dest_req,
	input  wire cdb_t [WAYS-1:0]               cdb,
	input  wire retire_t [WAYS-1:0]            retire,
	output logic [WAYS-1:0][1:0][PRN_W-1:0]    src_prn,
	output logic [WAYS-1:0][1:0]               src_ready,
	output logic [WAYS-1:0][PRN_W-1:0]         dest_prn,
	output logic                               stall
);

	logic [PRN_W-1:0]    rat [ARF_SIZE];        // speculative map
	logic [PRN_W-1:0]    rrat [ARF_SIZE];       // retired map
	logic [PRN_W-1:0]    free_list [FREE_SIZE];
	logic [FREE_W-1:0]   head;                  // next prn to hand out
	logic [FREE_W-1:0]   tail;                  // next slot for a freed prn
	logic [CNT_W-1:0]    count;
	logic [PRF_SIZE-1:0] ready;

	logic [CNT_W-1:0]             n_req, n_pop, n_push;
	logic [WAYS-1:0]              alloc;
	logic [WAYS-1:0][PRN_W-1:0]   freed;
	logic [WAYS-1:0][FREE_W-1:0]  push_ptr;
	logic [FREE_W-1:0]            tail_next;
	logic [PRN_W-1:0]             rrat_next [ARF_SIZE];

	// source lookups, no cdb bypass
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			for (int s = 0; s < 2; s++) begin
				src_prn[w][s]   = rat[src_arn[w][s]];
				src_ready[w][s] = ready[rat[src_arn[w][s]]];
			end
		end
	end

	////////////////////////////////////////
	// allocation, way 0 pops first
	////////////////////////////////////////

	always_comb begin
		logic [FREE_W-1:0] ptr;
		ptr   = head;
		n_req = '0;
		for (int w = 0; w < WAYS; w++) begin
			dest_prn[w] = free_list[ptr];
			if (dest_req[w]) begin
				ptr   = ptr + FREE_W'(1);
				n_req = n_req + CNT_W'(1);
			end
		end
		stall = (n_req > count);
		alloc = (stall || except) ? '0 : dest_req;
		n_pop = (stall || except) ? '0 : n_req;
	end

	// retirement, a later way sees an earlier way's update of the same arn
	always_comb begin
		logic [FREE_W-1:0] ptr;
		ptr    = tail;
		n_push = '0;
		for (int a = 0; a < ARF_SIZE; a++)
			rrat_next[a] = rrat[a];
		for (int w = 0; w < WAYS; w++) begin
			freed[w]    = rrat_next[retire[w].arn];  // old mapping goes back
			push_ptr[w] = ptr;
			if (retire[w].valid) begin
				rrat_next[retire[w].arn] = retire[w].prn;
				ptr    = ptr + FREE_W'(1);
				n_push = n_push + CNT_W'(1);
			end
		end
		tail_next = ptr;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int a = 0; a < ARF_SIZE; a++) begin
				rat[a]  <= PRN_W'(a);
				rrat[a] <= PRN_W'(a);
			end
			for (int i = 0; i < FREE_SIZE; i++)
				free_list[i] <= PRN_W'(ARF_SIZE + i);
			head  <= '0;
			tail  <= '0;
			count <= CNT_W'(FREE_SIZE);
			ready <= '1;
		end else begin
			for (int a = 0; a < ARF_SIZE; a++)
				rrat[a] <= rrat_next[a];
			for (int w = 0; w < WAYS; w++) begin
				if (retire[w].valid)
					free_list[push_ptr[w]] <= freed[w];
			end
			tail <= tail_next;
			if (except) begin
				// every in-flight prn sits between tail and head, so the ring is full again
				for (int a = 0; a < ARF_SIZE; a++)
					rat[a] <= rrat_next[a];
				ready <= '1;
				head  <= tail_next;
				count <= CNT_W'(FREE_SIZE);
			end else begin
				for (int w = 0; w < WAYS; w++) begin
					if (cdb[w].valid)
						ready[cdb[w].prn] <= 1'b1;
				end
				for (int w = 0; w < WAYS; w++) begin
					if (alloc[w]) begin
						rat[dest_arn[w]]    <= dest_prn[w];  // way 1 wins on equal rd
						ready[dest_prn[w]]  <= 1'b0;         // overrides cdb
					end
				end
				head  <= head + n_pop[FREE_W-1:0];
				count <= count - n_pop + n_push;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/prf.sv
`default_nettype none

module prf import id_pkg::*; (
	input  wire logic                          clock,
	input  wire logic                          rst,
	input  wire logic [2*WAYS-1:0][PRN_W-1:0]  rd_prn,
	output logic [2*WAYS-1:0][XLEN-1:0]        rd_data,
	input  wire cdb_t [WAYS-1:0]               cdb
);

	logic [XLEN-1:0] regs [PRF_SIZE];

	// read ports, new cdb data shows up a cycle later
	always_comb begin
		for (int r = 0; r < 2 * WAYS; r++)
			rd_data[r] = regs[rd_prn[r]];
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int p = 0; p < PRF_SIZE; p++)
				regs[p] <= '0;
		end else begin
			// later port wins on the same prn
			for (int w = 0; w < WAYS; w++) begin
				if (cdb[w].valid && cdb[w].prn != '0)  // prn 0 stays zero
					regs[cdb[w].prn] <= cdb[w].data;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`default_nettype none

module id_stage import id_pkg::*; (
	input  wire logic                   clock,
	input  wire logic                   rst,
	input  wire if_id_packet_t [WAYS-1:0] bundle,
	input  wire logic [WAYS-1:0]        predictions,
	input  wire cdb_t [WAYS-1:0]        cdb,
	input  wire retire_t [WAYS-1:0]     retire,
	input  wire logic                   except,
	output id_ex_packet_t [WAYS-1:0]    id_packet,
	output logic                        rename_stall
);

	decode_t [WAYS-1:0]              dec;
	logic [WAYS-1:0]                 killed;     // behind a predicted-taken way
	logic [WAYS-1:0]                 dest_req;
	logic [WAYS-1:0][ARN_W-1:0]      dest_arn;
	logic [WAYS-1:0][PRN_W-1:0]      alloc_prn;
	logic [WAYS-1:0][1:0][ARN_W-1:0] src_arn;    // [0] rs1, [1] rs2
	logic [WAYS-1:0][1:0][PRN_W-1:0] src_prn;
	logic [WAYS-1:0][1:0]            tab_ready, src_used, src_rdy;
	logic [WAYS-1:0][1:0][XLEN-1:0]  src_val;
	logic [2*WAYS-1:0][PRN_W-1:0]    rd_prn;
	logic [2*WAYS-1:0][XLEN-1:0]     rd_data;

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		decoder u_dec (
			.packet (bundle[w]),
			.dec    (dec[w])
		);

		assign dest_arn[w]    = bundle[w].instruction[11:7];
		assign src_arn[w][0]  = bundle[w].instruction[19:15];
		assign src_arn[w][1]  = bundle[w].instruction[24:20];
		assign rd_prn[2*w]    = src_prn[w][0];
		assign rd_prn[2*w+1]  = src_prn[w][1];
		// stores and branches read both sources whatever the operand selects say
		assign src_used[w][0] = (dec[w].opa_sel == OPA_RS1) || dec[w].wr_mem
			|| dec[w].cond_branch;
		assign src_used[w][1] = (dec[w].opb_sel == OPB_RS2) || dec[w].wr_mem
			|| dec[w].cond_branch;
	end

	////////////////////////////////////////
	// prediction cutoff and rename request
	////////////////////////////////////////

	always_comb begin
		logic taken;
		taken = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			killed[w]   = taken;
			dest_req[w] = dec[w].valid_inst && (dec[w].dest_sel == DEST_RD)
				&& (dest_arn[w] != '0) && !taken;
			if (dec[w].valid_inst && predictions[w])
				taken = 1'b1;
		end
	end

	rename_table u_rename (
		.clock     (clock),
		.rst       (rst),
		.except    (except),
		.src_arn   (src_arn),
		.dest_arn  (dest_arn),
		.dest_req  (dest_req),
		.cdb       (cdb),
		.retire    (retire),
		.src_prn   (src_prn),
		.src_ready (tab_ready),
		.dest_prn  (alloc_prn),
		.stall     (rename_stall)
	);

	prf u_prf (
		.clock   (clock),
		.rst     (rst),
		.rd_prn  (rd_prn),
		.rd_data (rd_data),
		.cdb     (cdb)
	);

	// source resolution, the nearest earlier way in the bundle overrides the table
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			for (int s = 0; s < 2; s++) begin
				src_rdy[w][s] = tab_ready[w][s];
				src_val[w][s] = tab_ready[w][s] ? rd_data[2*w+s] : XLEN'(src_prn[w][s]);
				for (int j = 0; j < w; j++) begin
					if (dest_req[j] && dest_arn[j] == src_arn[w][s]) begin
						src_rdy[w][s] = 1'b0;
						src_val[w][s] = XLEN'(alloc_prn[j]);  // tag to wait on
					end
				end
				if (!src_used[w][s] || src_arn[w][s] == '0) begin
					src_rdy[w][s] = 1'b1;
					src_val[w][s] = '0;
				end
			end
		end
	end

	////////////////////////////////////////
	// packet assembly
	////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			id_packet[w].pc            = bundle[w].pc;
			id_packet[w].npc           = bundle[w].npc;
			id_packet[w].instruction   = bundle[w].instruction;
			id_packet[w].opa_sel       = dec[w].opa_sel;
			id_packet[w].opb_sel       = dec[w].opb_sel;
			id_packet[w].alu_func      = dec[w].alu_func;
			id_packet[w].rd_mem        = dec[w].rd_mem;
			id_packet[w].wr_mem        = dec[w].wr_mem;
			id_packet[w].cond_branch   = dec[w].cond_branch;
			id_packet[w].uncond_branch = dec[w].uncond_branch;
			id_packet[w].csr_op        = dec[w].csr_op;
			id_packet[w].halt          = dec[w].halt;
			id_packet[w].illegal       = dec[w].illegal;
			id_packet[w].mem_size      = dec[w].mem_size;
			id_packet[w].valid_inst    = dec[w].valid_inst;
			id_packet[w].dest_prn      = dest_req[w] ? alloc_prn[w] : '0;
			id_packet[w].rs1_value     = src_val[w][0];
			id_packet[w].rs2_value     = src_val[w][1];
			id_packet[w].opa_ready     = src_rdy[w][0];
			id_packet[w].opb_ready     = src_rdy[w][1];
			id_packet[w].valid         = dec[w].valid_inst && !killed[w] && !rename_stall;
		end
	end

endmodule

`default_nettype wire

//--- bench/id_stage_properties.sv
`default_nettype none

module id_stage_properties import id_pkg::*; (
	input wire logic                       clock,
	input wire logic                       rst,
	input wire logic                       except,
	input wire logic                       stall,
	input wire logic [WAYS-1:0]            alloc,
	input wire logic [FREE_W-1:0]          head,
	input wire logic [CNT_W-1:0]           count,
	input wire logic [PRF_SIZE-1:0]        ready,
	input wire logic [WAYS-1:0][PRN_W-1:0] dest_prn
);

	// a stalled bundle leaves the free list head where it was
	a_stall_blocks: assert property (@(posedge clock) disable iff (rst)
		stall && !except |=> head == $past(head)) else $error("allocation while stalled");

	a_count_max: assert property (@(posedge clock) disable iff (rst)
		count <= CNT_W'(FREE_SIZE)) else $error("free count above depth");

	// allocation beats a same-cycle cdb write
	a_alloc0_busy: assert property (@(posedge clock) disable iff (rst)
		alloc[0] |=> !ready[$past(dest_prn[0])]) else $error("way 0 prn ready");

	a_alloc1_busy: assert property (@(posedge clock) disable iff (rst)
		alloc[1] |=> !ready[$past(dest_prn[1])]) else $error("way 1 prn ready");

endmodule

bind rename_table id_stage_properties u_props (.*);

`default_nettype wire

//--- bench/id_stage_tb.sv
`default_nettype none

module id_stage_tb import id_pkg::*; ();

	localparam int MAX_LINES = 200;  // trace read bound
	localparam int NFIELDS   = 31;

	logic                     clock;
	logic                     rst;
	if_id_packet_t [WAYS-1:0] bundle;
	logic [WAYS-1:0]          predictions;
	cdb_t [WAYS-1:0]          cdb;
	retire_t [WAYS-1:0]       retire;
	logic                     except;
	id_ex_packet_t [WAYS-1:0] id_packet;
	logic                     rename_stall;

	logic [31:0] f [NFIELDS];
	int          fd;
	int          lines;
	int          cycles;

	id_stage uut (
		.clock        (clock),
		.rst          (rst),
		.bundle       (bundle),
		.predictions  (predictions),
		.cdb          (cdb),
		.retire       (retire),
		.except       (except),
		.id_packet    (id_packet),
		.rename_stall (rename_stall)
	);

	always #10 clock = ~clock;

	////////////////////////////////////////
	// reporting and compares
	////////////////////////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic compare_field(input string name, input int way,
			input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("ERR cycle %0d id_packet[%0d].%s got %h expected %h",
				cycles, way, name, got, exp));
	endtask

	task automatic check_packet(input int way, input id_ex_packet_t got,
			input id_ex_packet_t exp);
		compare_field("valid", way, 32'(got.valid), 32'(exp.valid));
		compare_field("pc", way, got.pc, exp.pc);
		compare_field("npc", way, got.npc, exp.npc);
		compare_field("instruction", way, got.instruction, exp.instruction);
		compare_field("valid_inst", way, 32'(got.valid_inst), 32'(exp.valid_inst));
		compare_field("illegal", way, 32'(got.illegal), 32'(exp.illegal));
		compare_field("alu_func", way, 32'(got.alu_func), 32'(exp.alu_func));
		compare_field("opa_sel", way, 32'(got.opa_sel), 32'(exp.opa_sel));
		compare_field("opb_sel", way, 32'(got.opb_sel), 32'(exp.opb_sel));
		compare_field("rd_mem", way, 32'(got.rd_mem), 32'(exp.rd_mem));
		compare_field("wr_mem", way, 32'(got.wr_mem), 32'(exp.wr_mem));
		compare_field("cond_branch", way, 32'(got.cond_branch), 32'(exp.cond_branch));
		compare_field("uncond_branch", way, 32'(got.uncond_branch),
			32'(exp.uncond_branch));
		compare_field("csr_op", way, 32'(got.csr_op), 32'(exp.csr_op));
		compare_field("halt", way, 32'(got.halt), 32'(exp.halt));
		compare_field("mem_size", way, 32'(got.mem_size), 32'(exp.mem_size));
		compare_field("dest_prn", way, 32'(got.dest_prn), 32'(exp.dest_prn));
		compare_field("rs1_value", way, got.rs1_value, exp.rs1_value);
		compare_field("rs2_value", way, got.rs2_value, exp.rs2_value);
		compare_field("opa_ready", way, 32'(got.opa_ready), 32'(exp.opa_ready));
		compare_field("opb_ready", way, 32'(got.opb_ready), 32'(exp.opb_ready));
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("ERR cycle %0d rename_stall got %h expected %h",
				cycles, got, exp));
	endtask

	// pass-through fields and class flags that follow from the opcode alone
	function automatic id_ex_packet_t expected_flags(input id_ex_packet_t exp,
			input if_id_packet_t pkt);
		logic [6:0] opc;
		logic [2:0] f3;
		opc = pkt.instruction[6:0];
		f3  = pkt.instruction[14:12];
		exp.pc          = pkt.pc;
		exp.npc         = pkt.npc;
		exp.instruction = pkt.instruction;
		exp.valid_inst  = pkt.valid & ~exp.illegal;
		exp.mem_size    = MEM_BYTE;
		if (pkt.valid) begin
			exp.rd_mem        = (opc == OPC_LOAD);
			exp.wr_mem        = (opc == OPC_STORE);
			exp.cond_branch   = (opc == OPC_BRANCH);
			exp.uncond_branch = (opc == OPC_JAL) || (opc == OPC_JALR);
			exp.halt          = (pkt.instruction == WFI_INST);
			exp.csr_op        = (opc == OPC_SYSTEM) && (f3[1:0] != 2'b00);
			if ((exp.rd_mem || exp.wr_mem) && !exp.illegal)
				exp.mem_size = mem_size_e'(f3[1:0]);  // low funct3 bits give the size
		end
		return exp;
	endfunction

	////////////////////////////////////////
	// stimulus from one trace line
	////////////////////////////////////////

	task automatic drive_line();
		bundle[0].instruction = f[0];
		bundle[0].valid       = f[1][0];
		bundle[1].instruction = f[2];
		bundle[1].valid       = f[3][0];
		for (int w = 0; w < WAYS; w++) begin
			bundle[w].pc  = 32'(cycles * 8 + w * 4);
			bundle[w].npc = bundle[w].pc + 32'd4;
		end
		predictions = f[4][1:0];
		except      = f[5][0];
		cdb         = '0;  // way 1 buses stay idle
		retire      = '0;
		cdb[0].valid    = f[6][0];
		cdb[0].prn      = f[7][PRN_W-1:0];
		cdb[0].data     = f[8];
		retire[0].valid = f[9][0];
		retire[0].arn   = f[10][ARN_W-1:0];
		retire[0].prn   = f[11][PRN_W-1:0];
	endtask

	task automatic check_line();
		id_ex_packet_t exp;
		int            b;
		for (int w = 0; w < WAYS; w++) begin
			b = 12 + 9 * w;
			exp           = '0;
			exp.valid     = f[b][0];
			exp.illegal   = f[b+1][0];
			exp.alu_func  = alu_func_e'(f[b+2][4:0]);
			exp.opa_sel   = opa_sel_e'(f[b+3][1:0]);
			exp.opb_sel   = opb_sel_e'(f[b+4][2:0]);
			exp.dest_prn  = f[b+5][PRN_W-1:0];
			exp.rs1_value = f[b+6];
			exp.rs2_value = f[b+7];
			exp.opa_ready = f[b+8][0];  // rdy column is {opb, opa}
			exp.opb_ready = f[b+8][1];
			exp = expected_flags(exp, bundle[w]);
			check_packet(w, id_packet[w], exp);
		end
		check_stall(rename_stall, f[30][0]);
	endtask

	initial begin
		string line;
		int    n;
		clock       = 1'b0;
		rst         = 1'b1;
		bundle      = '0;
		predictions = '0;
		cdb         = '0;
		retire      = '0;
		except      = 1'b0;
		lines       = 0;
		cycles      = 0;
		fd = $fopen("bench/id_trace.txt", "r");
		if (fd == 0)
			stop_run("cannot open the trace file bench/id_trace.txt");
		repeat (4) @(posedge clock);
		#2;
		rst = 1'b0;
		while (!$feof(fd) && lines < MAX_LINES) begin
			lines++;
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
					f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
					f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29], f[30]);
				if (n != NFIELDS)
					stop_run($sformatf("trace line %0d has %0d fields, needs %0d",
						lines, n, NFIELDS));
				cycles++;
				drive_line();
				#17;  // just before the next edge
				check_line();
				@(posedge clock);
				#2;
			end
		end
		$fclose(fd);
		if (lines >= MAX_LINES)
			stop_run("timed out reading the trace, it has too many lines");
		if (cycles == 0) begin
			stop_run("the trace held no cycles to check");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/id_trace.txt
# i0 v0 i1 v1 pred except cdb_v cdb_prn cdb_data ret_v ret_arn ret_prn
# then per way: valid illegal alu opa opb dest rs1 rs2 rdy{opb,opa}; then stall
123450b7 1 00108133 1 0 0 0 0 0 0 0 0 1 0 0 2 4 20 0 0 3 1 0 0 0 0 21 20 20 0 0
00001197 1 0080026f 1 0 0 1 20 deadbeef 0 0 0 1 0 0 1 4 22 0 0 3 1 0 0 1 5 23 0 0 3 0
00708293 1 00010463 1 0 0 1 21 55 0 0 0 1 0 0 0 1 24 deadbeef 0 3 1 0 0 1 3 0 21 0 2 0
00010463 1 00110313 1 1 0 0 0 0 0 0 0 1 0 0 1 3 0 55 0 3 0 0 0 0 1 0 55 0 3 0
026283b3 1 0070a023 1 0 0 0 0 0 0 0 0 1 0 a 0 0 25 24 0 2 1 0 0 0 2 0 deadbeef 25 1 0
0041a403 1 ffffffff 1 0 0 0 0 0 0 0 0 1 0 0 0 1 26 22 0 2 0 1 0 0 0 0 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 27 0 0 3 1 0 0 0 1 28 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 29 0 0 3 1 0 0 0 1 2a 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 2b 0 0 3 1 0 0 0 1 2c 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 2d 0 0 3 1 0 0 0 1 2e 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 2f 0 0 3 1 0 0 0 1 30 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 31 0 0 3 1 0 0 0 1 32 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 33 0 0 3 1 0 0 0 1 34 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 35 0 0 3 1 0 0 0 1 36 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 37 0 0 3 1 0 0 0 1 38 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 39 0 0 3 1 0 0 0 1 3a 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 3b 0 0 3 1 0 0 0 1 3c 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 3d 0 0 3 1 0 0 0 1 3e 0 0 3 0
00000493 1 00000513 1 0 0 0 0 0 0 0 0 0 0 0 0 1 3f 0 0 3 0 0 0 0 1 20 0 0 3 1
00000493 1 00000513 1 0 0 0 0 0 1 1 20 0 0 0 0 1 3f 0 0 3 0 0 0 0 1 20 0 0 3 1
00000493 1 00000513 1 0 0 0 0 0 0 0 0 1 0 0 0 1 3f 0 0 3 1 0 0 0 1 1 0 0 3 0
00000000 0 00000000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 3 0
002085b3 1 00b48633 1 0 0 0 0 0 0 0 0 1 0 0 0 0 21 deadbeef 0 3 1 0 0 0 0 22 0 21 1 0

//--- verilog.f
common/id_pkg.sv
hdl/decoder.sv
rename/rename_table.sv
hdl/prf.sv
hdl/id_stage.sv
bench/id_stage_properties.sv
bench/id_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FLAGS     ?= --assert
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f verilog.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
